// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // cache geometry, simulation size
    localparam int NUM_WAYS        = 8;
    localparam int IDX_BITS        = 3;
    localparam int INDEX_BITS      = 2;
    localparam int OFFSET_BITS     = 2;
    localparam int ALIGN_BITS      = 3;
    localparam int DATA_WIDTH      = 64;
    localparam int CBUS_DATA_WIDTH = 32;
    localparam int BEATS           = 8;
    localparam int TAG_BITS        = 25;

    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [IDX_BITS-1:0]         idx_t;
    typedef logic [OFFSET_BITS-1:0]      offset_t;
    typedef logic [DATA_WIDTH-1:0]       data_t;
    typedef logic [CBUS_DATA_WIDTH-1:0]  cbus_data_t;
    typedef logic [2**ALIGN_BITS-1:0]    strobe_t;
    typedef logic [BEATS-1:0]            ready_t;
    typedef logic [NUM_WAYS-2:0]         select_t;

    // word offset in the upper bits, half select in bit 0
    typedef logic [$clog2(BEATS)-1:0]    beat_t;

    // per-set way arrays
    typedef logic [NUM_WAYS-1:0]         valid_array_t;
    typedef tag_t [NUM_WAYS-1:0]         tag_array_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic       shamt;
        logic [1:0] zeros;
    } addr_t;

    // data RAM word address
    typedef struct packed {
        idx_t    way;
        index_t  index;
        offset_t offset;
    } pos_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        data_t data;
        logic  index;
    } ibus_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } cbus_req_t;

    typedef struct packed {
        logic       okay;
        logic       last;
        cbus_data_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

// ==== tree_plru.sv ====
`default_nettype none

// heap-ordered tree: node n has children 2n+1 and 2n+2
// a bit of 1 means the victim lies in the right subtree
module tree_plru import icache_pkg::*; (
    input  select_t select,
    input  idx_t    hit_way,
    output idx_t    victim,
    output select_t new_select
);

    // follow the bits down to a leaf
    always_comb begin : victim_walk
        int node;
        node = 0;
        for (int lvl = IDX_BITS - 1; lvl >= 0; lvl--) begin
            victim[lvl] = select[node];
            node = 2 * node + 1 + int'(select[node]);
        end
    end

    // point every node on the accessed path away from it
    always_comb begin : update_walk
        int node;
        new_select = select;
        node = 0;
        for (int lvl = IDX_BITS - 1; lvl >= 0; lvl--) begin
            new_select[node] = ~hit_way[lvl];
            node = 2 * node + 1 + int'(hit_way[lvl]);
        end
    end

endmodule

`default_nettype wire

// ==== tag_store.sv ====
`default_nettype none

module tag_store import icache_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  index_t       index,
    input  logic         write_en,
    input  valid_array_t new_valid,
    input  tag_array_t   new_tags,
    input  select_t      new_select,
    output valid_array_t valid,
    output tag_array_t   tags,
    output select_t      select
);

    valid_array_t valid_q  [2**INDEX_BITS];
    tag_array_t   tags_q   [2**INDEX_BITS];
    select_t      select_q [2**INDEX_BITS];

    // whole set visible in the same cycle
    assign valid  = valid_q[index];
    assign tags   = tags_q[index];
    assign select = select_q[index];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < 2**INDEX_BITS; s++) begin
                valid_q[s]  <= '0;
                select_q[s] <= '0;
            end
        end else if (write_en) begin
            valid_q[index]  <= new_valid;
            select_q[index] <= new_select;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tags_q[index] <= new_tags;
        end
    end

    assert property (@(posedge clk) resetn |-> !write_en)
        else $error("tag store written during reset");

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none

// port 1 reads for hits, port 2 takes refill beats
module data_ram import icache_pkg::*; (
    input  logic    clk,
    input  pos_t    read_pos,
    output data_t   read_data,
    input  pos_t    write_pos,
    input  strobe_t write_strobe,
    input  data_t   write_data
);

    data_t mem [2**$bits(pos_t)];

    always_ff @(posedge clk) begin
        read_data <= mem[read_pos];
    end

    // byte lanes, one half of a word per beat
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2**ALIGN_BITS; b++) begin
            if (write_strobe[b]) begin
                mem[write_pos][8*b +: 8] <= write_data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_refill.sv ====
`default_nettype none

module line_refill import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  addr_t      start_addr,
    input  idx_t       start_way,
    input  cbus_resp_t cbus_resp,
    output logic       busy,
    output idx_t       line_way,
    output index_t     line_index,
    output ready_t     ready,
    output pos_t       write_pos,
    output strobe_t    write_strobe,
    output data_t      write_data,
    output cbus_req_t  cbus_req
);

    logic   busy_q;
    ready_t ready_q;
    addr_t  addr_q;
    idx_t   way_q;
    beat_t  count_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy_q  <= 1'b0;
            ready_q <= '0;
        end else if (start) begin
            busy_q  <= 1'b1;
            ready_q <= '0;
        end else begin
            if (cbus_resp.okay) begin
                ready_q[count_q] <= 1'b1;
            end
            if (cbus_resp.last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // critical beat first, counter wraps around the line
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= start_addr;
            way_q   <= start_way;
            count_q <= {start_addr.offset, start_addr.shamt};
        end else if (cbus_resp.okay) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign write_pos.way    = way_q;
    assign write_pos.index  = addr_q.index;
    assign write_pos.offset = count_q[$bits(beat_t)-1:1];

    // low or high half of the word, by bit 0 of the beat
    assign write_strobe = cbus_resp.okay ?
        strobe_t'({(CBUS_DATA_WIDTH / 8){1'b1}}) << (CBUS_DATA_WIDTH / 8 * count_q[0]) :
        '0;
    assign write_data   = {(DATA_WIDTH / CBUS_DATA_WIDTH){cbus_resp.rdata}};

    assign busy       = busy_q;
    assign line_way   = way_q;
    assign line_index = addr_q.index;
    assign ready      = ready_q;

    assign cbus_req.valid = busy_q;
    assign cbus_req.addr  = addr_q;

    assert property (@(posedge clk) disable iff (resetn) cbus_resp.okay |-> busy_q)
        else $error("cache bus beat without a refill");
    assert property (@(posedge clk) disable iff (resetn) cbus_resp.last |-> cbus_resp.okay)
        else $error("last without okay");

endmodule

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

module icache import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  ibus_req_t  ibus_req,
    output ibus_resp_t ibus_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    addr_t req_addr;
    assign req_addr = ibus_req.addr;

    // tag, valid and PLRU storage
    valid_array_t set_valid, new_valid;
    tag_array_t   set_tags, new_tags;
    select_t      set_select, new_select;
    logic         tag_write;

    tag_store u_tag_store (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req_addr.index),
        .write_en   (tag_write),
        .new_valid  (new_valid),
        .new_tags   (new_tags),
        .new_select (new_select),
        .valid      (set_valid),
        .tags       (set_tags),
        .select     (set_select)
    );

    // tag compare across all ways
    logic [NUM_WAYS-1:0] hit_bits;
    logic                req_hit;
    idx_t                hit_way;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_compare
        assign hit_bits[i] = set_valid[i] && set_tags[i] == req_addr.tag;
    end

    assign req_hit = |hit_bits;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hit_bits[i]) begin
                hit_way = idx_t'(i);
            end
        end
    end

    idx_t    plru_victim;
    select_t plru_select;

    tree_plru u_tree_plru (
        .select     (set_select),
        .hit_way    (hit_way),
        .victim     (plru_victim),
        .new_select (plru_select)
    );

    // refill state
    logic    refill_busy;
    idx_t    refill_way;
    index_t  refill_index;
    ready_t  refill_ready;
    pos_t    refill_pos;
    strobe_t refill_strobe;
    data_t   refill_data;
    logic    to_hit, to_miss;

    line_refill u_line_refill (
        .clk          (clk),
        .resetn       (resetn),
        .start        (to_miss),
        .start_addr   (req_addr),
        .start_way    (plru_victim),
        .cbus_resp    (cbus_resp),
        .busy         (refill_busy),
        .line_way     (refill_way),
        .line_index   (refill_index),
        .ready        (refill_ready),
        .write_pos    (refill_pos),
        .write_strobe (refill_strobe),
        .write_data   (refill_data),
        .cbus_req     (cbus_req)
    );

    // a hit on the refilling line waits for its beat
    beat_t req_beat;
    logic  req_in_refill;
    logic  req_ready;

    assign req_beat      = {req_addr.offset, req_addr.shamt};
    assign req_in_refill = refill_busy && hit_way == refill_way &&
                           req_addr.index == refill_index;
    assign req_ready     = req_hit && (!req_in_refill || refill_ready[req_beat]);

    assign to_hit  = ibus_req.req && req_ready;
    // a new refill may start in the cycle that carries last
    assign to_miss = ibus_req.req && !req_hit && (!refill_busy || cbus_resp.last);

    assign tag_write = !resetn && (to_hit || to_miss);

    always_comb begin
        new_valid  = set_valid;
        new_tags   = set_tags;
        new_select = set_select;
        if (to_miss) begin
            new_valid[plru_victim] = 1'b1;
            new_tags[plru_victim]  = req_addr.tag;
        end else if (to_hit) begin
            new_select = plru_select;
        end
    end

    pos_t  hit_pos;
    data_t hit_data;

    assign hit_pos.way    = hit_way;
    assign hit_pos.index  = req_addr.index;
    assign hit_pos.offset = req_addr.offset;

    data_ram u_data_ram (
        .clk          (clk),
        .read_pos     (hit_pos),
        .read_data    (hit_data),
        .write_pos    (refill_pos),
        .write_strobe (refill_strobe),
        .write_data   (refill_data)
    );

    // response stage, lines up with the RAM read
    logic data_ok_q;
    logic index_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= to_hit;
        end
    end

    always_ff @(posedge clk) begin
        index_q <= req_addr.shamt;
    end

    assign ibus_resp.addr_ok = req_ready;
    assign ibus_resp.data_ok = data_ok_q;
    assign ibus_resp.data    = hit_data;
    assign ibus_resp.index   = index_q;

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_bits))
        else $error("request tag found in more than one way");

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

// free running testbench clock, period 10
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache import icache_pkg::*; ();

    localparam int WAIT_LIMIT = 200;
    localparam int MAX_VECS   = 32;

    logic       clk;
    logic       resetn;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    tb_clock u_clock (.clk(clk));

    icache i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .ibus_req  (ibus_req),
        .ibus_resp (ibus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    logic [71:0] vecs [MAX_VECS];
    int          bursts;
    bit          mem_busy;
    cbus_req_t   last_burst;

    // reference cache state, tree PLRU per set
    bit      model_valid [2**INDEX_BITS][NUM_WAYS];
    tag_t    model_tag   [2**INDEX_BITS][NUM_WAYS];
    select_t model_sel   [2**INDEX_BITS];

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_resp(input ibus_resp_t got, input ibus_resp_t exp);
        if (got.index !== exp.index) begin
            report_failure($sformatf("CHECK FAILED ibus_resp.index: got %h expected %h",
                                     got.index, exp.index));
        end
        if (got.data[32*exp.index +: 32] !== exp.data[32*exp.index +: 32]) begin
            report_failure($sformatf("CHECK FAILED ibus_resp.data: got %h expected %h",
                                     got.data[32*exp.index +: 32],
                                     exp.data[32*exp.index +: 32]));
        end
    endtask

    task automatic check_cbus(input cbus_req_t got, input cbus_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED cbus_req.addr: got %h expected %h",
                                     got.addr, exp.addr));
        end
    endtask

    task automatic check_way(input idx_t got, input idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED i_dut.refill_way: got %h expected %h",
                                     got, exp));
        end
    endtask

    // instruction word held by memory at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic addr_t beat_addr(input logic [31:0] base, input beat_t beat);
        return {base[31:5], beat, 2'b00};
    endfunction

    // memory side, wrapping burst from the requested beat
    initial begin : memory_model
        beat_t beat;
        int    gap;
        cbus_resp  = '0;
        bursts     = 0;
        mem_busy   = 1'b0;
        forever begin
            @(posedge clk);
            if (!resetn && cbus_req.valid) begin
                last_burst = cbus_req;
                bursts     = bursts + 1;
                mem_busy   = 1'b1;
                beat       = cbus_req.addr[4:2];
                for (int n = 0; n < BEATS; n++) begin
                    gap = $urandom % 3;
                    cbus_resp <= '0;
                    repeat (gap) @(posedge clk);
                    cbus_resp.okay  <= 1'b1;
                    cbus_resp.last  <= (n == BEATS - 1);
                    cbus_resp.rdata <= mem_word(beat_addr(last_burst.addr, beat));
                    beat = beat + 1'b1;
                    @(posedge clk);
                end
                cbus_resp <= '0;
                mem_busy = 1'b0;
            end
        end
    end

    // returns the predicted outcome and the way that ends up holding the line
    task automatic model_access(input addr_t a, output bit miss, output idx_t way);
        select_t s;
        int      node;
        miss = 1'b1;
        way  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[a.index][w] && model_tag[a.index][w] == a.tag) begin
                miss = 1'b0;
                way  = idx_t'(w);
            end
        end
        s = model_sel[a.index];
        if (miss) begin
            node = 0;
            for (int lvl = IDX_BITS - 1; lvl >= 0; lvl--) begin
                way[lvl] = s[node];
                node = 2 * node + 1 + int'(s[node]);
            end
            model_valid[a.index][way] = 1'b1;
            model_tag[a.index][way]   = a.tag;
        end
        // the refetch after a miss is a hit on the new way
        node = 0;
        for (int lvl = IDX_BITS - 1; lvl >= 0; lvl--) begin
            s[node] = ~way[lvl];
            node = 2 * node + 1 + int'(way[lvl]);
        end
        model_sel[a.index] = s;
    endtask

    task automatic apply_reset(input addr_t hold_addr);
        int waited;
        waited = 0;
        while (mem_busy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout waiting for the memory burst to finish before reset");
            end
            @(posedge clk);
        end
        // a fetch to a cached line stays on the bus and must get no answer
        resetn        <= 1'b1;
        ibus_req.req  <= 1'b1;
        ibus_req.addr <= hold_addr;
        repeat (3) begin
            @(posedge clk);
            if (ibus_resp.data_ok === 1'b1) begin
                report_failure("data_ok went high during reset");
            end
        end
        resetn   <= 1'b0;
        ibus_req <= '0;
        @(posedge clk);
        if (ibus_resp.data_ok !== 1'b0) begin
            report_failure("data_ok not low right after reset");
        end
        for (int s = 0; s < 2**INDEX_BITS; s++) begin
            model_sel[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic do_fetch(input addr_t a, input bit exp_miss, input logic [31:0] exp_word,
                            input idx_t exp_way);
        int         start_bursts;
        int         waited;
        bit         quiet;
        ibus_resp_t exp_resp;
        start_bursts = bursts;
        quiet        = !mem_busy;
        waited       = 0;
        ibus_req.req  <= 1'b1;
        ibus_req.addr <= a;
        @(posedge clk);
        while (ibus_resp.addr_ok !== 1'b1) begin
            if (ibus_resp.data_ok === 1'b1) begin
                report_failure("data_ok without an accepted request");
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("timeout waiting for addr_ok at address %h", a));
            end
            @(posedge clk);
        end
        ibus_req <= '0;
        @(posedge clk);
        if (ibus_resp.data_ok !== 1'b1) begin
            report_failure("data_ok missing one cycle after addr_ok");
        end
        exp_resp         = '0;
        exp_resp.data_ok = 1'b1;
        exp_resp.data    = {2{exp_word}};
        exp_resp.index   = a.shamt;
        check_resp(ibus_resp, exp_resp);
        if ((bursts != start_bursts) != exp_miss) begin
            report_failure($sformatf("address %h: expected a %s, cache bus disagrees",
                                     a, exp_miss ? "miss" : "hit"));
        end
        // filled line, nothing in flight
        if (!exp_miss && quiet && waited != 0) begin
            report_failure($sformatf("hit at %h was not accepted in its request cycle", a));
        end
        if (exp_miss) begin
            check_cbus(last_burst, '{valid: 1'b1, addr: a});
            check_way(i_dut.refill_way, exp_way);
        end
    endtask

    initial begin : main
        logic [3:0] cmd;
        addr_t      addr;
        addr_t      last_addr;
        bit         file_miss;
        bit         model_miss;
        idx_t       way;
        logic [31:0] word;
        void'($urandom(32'hb127_1e4b));
        resetn    = 1'b1;
        ibus_req  = '0;
        last_addr = '0;
        for (int i = 0; i < MAX_VECS; i++) begin
            vecs[i] = {4'hf, 68'h0};
        end
        $readmemh("icache_testdata.txt", vecs);
        apply_reset(last_addr);
        for (int i = 0; i < MAX_VECS && vecs[i][71:68] != 4'hf; i++) begin
            cmd       = vecs[i][71:68];
            addr      = vecs[i][67:36];
            file_miss = vecs[i][35:32] != 4'h0;
            word      = vecs[i][31:0];
            if (cmd == 4'h1) begin
                apply_reset(last_addr);
            end else begin
                model_access(addr, model_miss, way);
                if (model_miss != file_miss) begin
                    report_failure($sformatf("line %0d of the data file disagrees with PLRU model",
                                             i));
                end
                if (word !== mem_word(addr)) begin
                    report_failure($sformatf("line %0d of the data file breaks the memory rule",
                                             i));
                end
                do_fetch(addr, file_miss, word, way);
                last_addr = addr;
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_testdata.txt ====
// columns: command _ address _ outcome _ instruction
// command 0 fetch, 1 reset, f end; outcome 1 miss, 0 hit
0_00001008_1_5a5a1008
0_0000101c_0_5a5a101c
0_00001004_0_5a5a1004
0_00001010_0_5a5a1010
0_00001064_1_5a5a1064
0_00002000_1_5a5a2000
0_00003000_1_5a5a3000
0_00004000_1_5a5a4000
0_00005000_1_5a5a5000
0_00006000_1_5a5a6000
0_00007000_1_5a5a7000
0_00008000_1_5a5a8000
0_00009000_1_5a5a9000
0_00002004_0_5a5a2004
0_00001000_1_5a5a1000
0_00003008_1_5a5a3008
0_0000500c_0_5a5a500c
1_00000000_0_00000000
0_00002004_1_5a5a2004
0_0000200c_0_5a5a200c
f_00000000_0_00000000

// ==== flist.f ====
icache_pkg.sv
tree_plru.sv
tag_store.sv
data_ram.sv
line_refill.sv
icache.sv
tb_clock.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_icache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_icache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
